// ==== filelist.f ====
+incdir+src
src/lc3b_isa_pkg.sv
src/lc3b_rob_pkg.sv
src/rob_queue.sv
src/commit_control.sv
src/arch_regfile.sv
src/commit_top.sv
verification/commit_assertions.sv
verification/commit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the commit-stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

if ! verilator --binary --timing --assert --top-module commit_tb -f filelist.f -o commit_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/commit_sim +verilator+error+limit+100 > "$log_file" 2>&1
status=$?
cat "$log_file"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$log_file"; then
	exit 1
fi

exit 0

// ==== src/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
	import lc3b_isa_pkg::*, lc3b_rob_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,

	input  logic         rename_valid,
	input  lc3b_reg      rename_reg,
	input  lc3b_rob_addr rename_tag,

	input  reg_commit_t  reg_commit,
	input  logic         flush,

	input  lc3b_reg      lookup_reg,
	output lc3b_rob_addr cur_tag,

	input  lc3b_reg      rd_sel,
	output lc3b_word     rd_value,
	output logic         rd_busy
);

	localparam int num_regs = 1 << $bits(lc3b_reg);

	lc3b_word      value_q [num_regs];
	lc3b_rob_addr  tag_q [num_regs]; // Youngest producer per register
	logic [num_regs-1:0] busy_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				value_q[i] <= '0;
				tag_q[i]   <= '0;
			end
			busy_q <= '0;
		end else begin
			if (reg_commit.ld_value) begin
				value_q[reg_commit.dest] <= reg_commit.value;
			end
			if (flush) begin
				busy_q <= '0; // All in-flight producers squashed
			end else begin
				if (reg_commit.ld_busy && (tag_q[reg_commit.dest] == reg_commit.tag)) begin
					busy_q[reg_commit.dest] <= 1'b0;
				end
				// Rename comes last so it wins a same-cycle clear
				if (rename_valid) begin
					busy_q[rename_reg] <= 1'b1;
					tag_q[rename_reg]  <= rename_tag;
				end
			end
		end
	end

	assign cur_tag  = tag_q[lookup_reg];
	assign rd_value = value_q[rd_sel];
	assign rd_busy  = busy_q[rd_sel];

endmodule

`default_nettype wire

// ==== src/commit_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_control
	import lc3b_isa_pkg::*, lc3b_rob_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,

	input  logic         head_valid,
	input  rob_entry_t   head_entry,
	input  lc3b_rob_addr head_tag,
	input  lc3b_rob_addr cur_tag, // Tag the regfile holds for head dest
	input  logic         dmem_resp,

	output logic         retire,
	output reg_commit_t  reg_commit,
	output redirect_t    redirect,
	output logic         flush,
	output logic         dmem_write,
	output logic         ldstr_re
);

	typedef enum logic {
		cs_idle,
		cs_store_wait
	} commit_state_t;

	commit_state_t state_q;
	commit_state_t state_d;

	lc3b_nzp nzp_q;
	lc3b_nzp gencc;
	logic    ld_cc;
	logic    br_taken;

	// ####################
	// Condition codes
	// ####################

	assign gencc = {head_entry.value[$bits(lc3b_word)-1], // n
		head_entry.value == '0, // z
		!head_entry.value[$bits(lc3b_word)-1] && (head_entry.value != '0)}; // p

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			nzp_q <= 3'b010; // Z after reset
		end else if (ld_cc) begin
			nzp_q <= gencc;
		end
	end

	assign br_taken = |(head_entry.dest & nzp_q); // Mask shares a bit with cc

	// ####################
	// Retire decisions
	// ####################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= cs_idle;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d    = state_q;
		retire     = 1'b0;
		ld_cc      = 1'b0;
		flush      = 1'b0;
		ldstr_re   = 1'b0;
		reg_commit = '{dest: head_entry.dest, value: head_entry.value, tag: head_tag,
			ld_value: 1'b0, ld_busy: 1'b0};
		redirect   = '{pcmux_sel: 1'b0, new_pc: head_entry.value}; // Target comes from value
		case (state_q)
			cs_idle: begin
				if (head_valid) begin
					case (head_entry.opcode)
						op_br: begin
							retire = 1'b1;
							if (br_taken != head_entry.predict) begin
								redirect.pcmux_sel = 1'b1; // Mispredict
								flush = 1'b1;
							end
						end
						op_str, op_stb: begin
							state_d = cs_store_wait; // Hold head for memory
						end
						default: begin
							retire = 1'b1; // Non-writers retire silently
							if (op_writes_reg(head_entry.opcode)) begin
								reg_commit.ld_value = 1'b1;
								reg_commit.ld_busy = (cur_tag == head_tag); // Skip if renamed again
								ld_cc = (head_entry.opcode != op_jsr); // jsr leaves cc alone
							end
						end
					endcase
				end
			end
			cs_store_wait: begin
				if (dmem_resp) begin
					retire   = 1'b1;
					ldstr_re = 1'b1; // Release the store buffer entry
					state_d  = cs_idle;
				end
			end
			default: state_d = cs_idle;
		endcase
	end

	assign dmem_write = (state_q == cs_store_wait);

endmodule

`default_nettype wire

// ==== src/commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_top
	import lc3b_isa_pkg::*, lc3b_rob_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,

	input  logic          alloc_valid,
	input  rob_alloc_t    alloc,
	output lc3b_rob_addr  alloc_tag,
	output logic          rob_full,

	input  logic          complete_valid,
	input  rob_complete_t complete,

	output logic          dmem_write,
	input  logic          dmem_resp,

	input  lc3b_reg       rd_sel,
	output lc3b_word      rd_value,
	output logic          rd_busy,

	output redirect_t     redirect,
	output logic          flush,
	output logic          ldstr_re,
	output logic          rob_empty
);

	logic         head_valid;
	rob_entry_t   head_entry;
	lc3b_rob_addr head_tag;
	lc3b_rob_addr cur_tag;
	logic         retire;
	reg_commit_t  reg_commit;
	logic         rename_valid;

	// Accepted allocation of a register writer claims its destination
	assign rename_valid = alloc_valid && !rob_full && op_writes_reg(alloc.opcode);

	rob_queue u_rob_queue (
		.clk,
		.arst_n,
		.alloc_valid,
		.alloc,
		.alloc_tag,
		.complete_valid,
		.complete,
		.retire,
		.flush,
		.head_valid,
		.head_entry,
		.head_tag,
		.rob_full,
		.rob_empty
	);

	commit_control u_commit_control (
		.clk,
		.arst_n,
		.head_valid,
		.head_entry,
		.head_tag,
		.cur_tag,
		.dmem_resp,
		.retire,
		.reg_commit,
		.redirect,
		.flush,
		.dmem_write,
		.ldstr_re
	);

	arch_regfile u_arch_regfile (
		.clk,
		.arst_n,
		.rename_valid,
		.rename_reg (alloc.dest),
		.rename_tag (alloc_tag),
		.reg_commit,
		.flush,
		.lookup_reg (head_entry.dest), // Second read port for commit
		.cur_tag,
		.rd_sel,
		.rd_value,
		.rd_busy
	);

endmodule

`default_nettype wire

// ==== src/lc3b_config.svh ====
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// ####################
// Core sizing
// ####################

// Width of a data word or a PC value
`define LC3B_DATA_WIDTH 16

// Width of a reorder-buffer tag
`define LC3B_TAG_WIDTH 3

// Reorder-buffer entries, two to the tag width
`define LC3B_ROB_DEPTH 8

`endif

// ==== src/lc3b_isa_pkg.sv ====
`default_nettype none

`include "lc3b_config.svh"

package lc3b_isa_pkg;

	typedef logic [`LC3B_DATA_WIDTH-1:0] lc3b_word; // Data or PC
	typedef logic [2:0] lc3b_reg; // R0..R7
	typedef logic [2:0] lc3b_nzp; // {n, z, p}

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Opcodes that rename and later write a destination register
	function automatic logic op_writes_reg(lc3b_opcode op);
		case (op)
			op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb, op_ldi, op_jsr: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== src/lc3b_rob_pkg.sv ====
`default_nettype none

`include "lc3b_config.svh"

package lc3b_rob_pkg;

	import lc3b_isa_pkg::*;

	typedef logic [`LC3B_TAG_WIDTH-1:0] lc3b_rob_addr; // Entry index, also the rename tag

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dest; // nzp mask for branches
		lc3b_word   value; // Result, or target PC for branches
		logic       predict; // Predicted taken
		logic       done;
	} rob_entry_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dest;
		logic       predict;
	} rob_alloc_t;

	typedef struct packed {
		lc3b_rob_addr tag;
		lc3b_word     value;
	} rob_complete_t;

	// Write request from commit into the register file
	typedef struct packed {
		lc3b_reg      dest;
		lc3b_word     value;
		lc3b_rob_addr tag; // Tag of the retiring entry
		logic         ld_value;
		logic         ld_busy; // Clear busy mark
	} reg_commit_t;

	typedef struct packed {
		logic     pcmux_sel;
		lc3b_word new_pc;
	} redirect_t;

endpackage

`default_nettype wire

// ==== src/rob_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module rob_queue
	import lc3b_rob_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,

	input  logic          alloc_valid,
	input  rob_alloc_t    alloc,
	output lc3b_rob_addr  alloc_tag,

	input  logic          complete_valid,
	input  rob_complete_t complete,

	input  logic          retire,
	input  logic          flush,

	output logic          head_valid,
	output rob_entry_t    head_entry,
	output lc3b_rob_addr  head_tag,
	output logic          rob_full,
	output logic          rob_empty
);

	localparam int tag_w = `LC3B_TAG_WIDTH;

	rob_entry_t entries [`LC3B_ROB_DEPTH];

	logic [tag_w:0] head_q; // Extra bit tells full from empty
	logic [tag_w:0] tail_q;
	lc3b_rob_addr   head_idx;
	lc3b_rob_addr   tail_idx;
	logic           alloc_fire;

	assign head_idx = head_q[tag_w-1:0];
	assign tail_idx = tail_q[tag_w-1:0];

	assign rob_empty  = (head_q == tail_q);
	assign rob_full   = (head_q[tag_w] != tail_q[tag_w]) && (head_idx == tail_idx);
	assign alloc_fire = alloc_valid && !rob_full && !flush; // Dropped on flush

	// ####################
	// Pointers
	// ####################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head_q <= '0;
			tail_q <= '0;
		end else if (flush) begin
			head_q <= '0; // Whole buffer squashed
			tail_q <= '0;
		end else begin
			if (retire) begin
				head_q <= head_q + 1'b1;
			end
			if (alloc_fire) begin
				tail_q <= tail_q + 1'b1;
			end
		end
	end

	// ####################
	// Entry storage
	// ####################

	always_ff @(posedge clk) begin
		if (alloc_fire) begin
			entries[tail_idx].opcode  <= alloc.opcode;
			entries[tail_idx].dest    <= alloc.dest;
			entries[tail_idx].value   <= '0;
			entries[tail_idx].predict <= alloc.predict;
			entries[tail_idx].done    <= 1'b0;
		end
		if (complete_valid) begin
			entries[complete.tag].value <= complete.value; // Results come back by tag
			entries[complete.tag].done  <= 1'b1;
		end
	end

	assign alloc_tag  = tail_idx;
	assign head_tag   = head_idx;
	assign head_entry = entries[head_idx];
	assign head_valid = !rob_empty && entries[head_idx].done; // Oldest entry ready to retire

endmodule

`default_nettype wire

// ==== verification/commit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_assertions
	import lc3b_rob_pkg::*;
(
	input logic         clk,
	input logic         arst_n,
	input logic         retire,
	input logic         flush,
	input logic         pcmux_sel,
	input logic         ldstr_re,
	input logic         dmem_write,
	input logic         dmem_resp,
	input logic         rob_empty,
	input logic         rob_full,
	input logic         alloc_valid,
	input lc3b_rob_addr alloc_tag
);

	int unsigned fail_count = 0; // Read by the testbench at the end

	a_flush_redirect: assert property (@(posedge clk) disable iff (!arst_n)
		flush |-> pcmux_sel)
		else begin
			$error("flush raised without pcmux_sel");
			fail_count++;
		end

	a_release_resp: assert property (@(posedge clk) disable iff (!arst_n)
		ldstr_re |-> dmem_resp && retire)
		else begin
			$error("ldstr_re raised outside a dmem_resp retire");
			fail_count++;
		end

	a_store_hold: assert property (@(posedge clk) disable iff (!arst_n)
		dmem_write && !dmem_resp |=> dmem_write)
		else begin
			$error("dmem_write dropped before dmem_resp");
			fail_count++;
		end

	a_flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> rob_empty)
		else begin
			$error("ROB not empty after flush");
			fail_count++;
		end

	// Tail must not move while the buffer is full
	a_full_blocks: assert property (@(posedge clk) disable iff (!arst_n)
		rob_full && alloc_valid && !flush |=> $stable(alloc_tag))
		else begin
			$error("allocation accepted while ROB full");
			fail_count++;
		end

endmodule

bind commit_top commit_assertions u_commit_assertions (
	.clk,
	.arst_n,
	.retire,
	.flush,
	.pcmux_sel   (redirect.pcmux_sel),
	.ldstr_re,
	.dmem_write,
	.dmem_resp,
	.rob_empty,
	.rob_full,
	.alloc_valid,
	.alloc_tag
);

`default_nettype wire

// ==== verification/commit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module commit_tb
	import lc3b_isa_pkg::*, lc3b_rob_pkg::*;
();

	localparam int clk_period = 20;
	localparam int num_ops    = 44; // Allocations over all sequences
	localparam int depth      = `LC3B_ROB_DEPTH;

	logic          clk;
	logic          arst_n;
	logic          alloc_valid;
	rob_alloc_t    alloc;
	lc3b_rob_addr  alloc_tag;
	logic          rob_full;
	logic          complete_valid;
	rob_complete_t complete;
	logic          dmem_write;
	logic          dmem_resp;
	lc3b_reg       rd_sel;
	lc3b_word      rd_value;
	logic          rd_busy;
	redirect_t     redirect;
	logic          flush;
	logic          ldstr_re;
	logic          rob_empty;

	int seed     = 37;
	int errors   = 0;
	int head_ptr = 0; // Program-order counters that wrap onto tags
	int tail_ptr = 0;

	// ####################
	// Reference model
	// ####################

	lc3b_word     ref_val [8];
	lc3b_rob_addr ref_tag [8];
	logic [7:0]   ref_busy;
	lc3b_nzp      ref_nzp;
	lc3b_opcode   prog_op [depth];
	lc3b_reg      prog_dest [depth];
	logic         prog_pred [depth];
	lc3b_word     prog_val [depth];
	lc3b_opcode   alu_ops [8] = '{op_add, op_and, op_not, op_shf,
		op_lea, op_ldr, op_ldb, op_ldi};

	commit_top u_commit_top (
		.clk,
		.arst_n,
		.alloc_valid,
		.alloc,
		.alloc_tag,
		.rob_full,
		.complete_valid,
		.complete,
		.dmem_write,
		.dmem_resp,
		.rd_sel,
		.rd_value,
		.rd_busy,
		.redirect,
		.flush,
		.ldstr_re,
		.rob_empty
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic writes_reg(lc3b_opcode op);
		return op inside {op_add, op_and, op_not, op_shf, op_lea,
			op_ldr, op_ldb, op_ldi, op_jsr};
	endfunction

	function automatic lc3b_nzp cc_of(lc3b_word v);
		if (v[15]) begin
			return 3'b100;
		end
		if (v == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_regs();
		for (int r = 0; r < 8; r++) begin
			rd_sel = lc3b_reg'(r);
			#0.5;
			compare_value($sformatf("rd_value[R%0d]", r), rd_value, ref_val[r]);
			compare_value($sformatf("rd_busy[R%0d]", r), 16'(rd_busy), 16'(ref_busy[r]));
		end
	endtask

	// Held until the model says the buffer has room
	task automatic alloc_op(input lc3b_opcode op, input lc3b_reg dest, input logic pred,
		input lc3b_word val);
		logic accepted;
		int   t;
		accepted = 1'b0;
		alloc_valid = 1'b1;
		alloc = '{opcode: op, dest: dest, predict: pred};
		while (!accepted) begin
			@(negedge clk);
			t = tail_ptr % depth;
			accepted = (tail_ptr - head_ptr) < depth;
			compare_value("alloc_tag", 16'(alloc_tag), 16'(t));
			compare_value("rob_full", 16'(rob_full), 16'(!accepted));
			if (accepted) begin
				prog_op[t] = op;
				prog_dest[t] = dest;
				prog_pred[t] = pred;
				prog_val[t] = val;
				if (writes_reg(op)) begin
					ref_busy[dest] = 1'b1;
					ref_tag[dest] = lc3b_rob_addr'(t);
				end
				tail_ptr++;
			end
			@(posedge clk);
			#2;
		end
		alloc_valid = 1'b0;
	endtask

	task automatic complete_op(input int tag);
		complete_valid = 1'b1;
		complete = '{tag: lc3b_rob_addr'(tag), value: prog_val[tag]};
		@(posedge clk);
		#2;
		complete_valid = 1'b0;
	endtask

	task automatic complete_batch(input int first, input int n, input logic shuffle);
		int order [depth];
		int j;
		int tmp;
		for (int i = 0; i < n; i++) begin
			order[i] = shuffle ? (first + i) % depth : (first + n - 1 - i) % depth;
		end
		for (int i = n - 1; i > 0 && shuffle; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < n; i++) begin
			complete_op(order[i]);
		end
	endtask

	// Waits for the head to retire and checks it against the model
	task automatic retire_next();
		int   t;
		logic taken;
		logic mis;
		logic is_store;
		t = head_ptr % depth;
		@(negedge clk);
		while (!u_commit_top.retire) @(negedge clk);
		taken = |(prog_dest[t] & ref_nzp);
		mis = (prog_op[t] == op_br) && (taken != prog_pred[t]);
		is_store = prog_op[t] inside {op_str, op_stb};
		compare_value("flush", 16'(flush), 16'(mis));
		compare_value("pcmux_sel", 16'(redirect.pcmux_sel), 16'(mis));
		compare_value("ldstr_re", 16'(ldstr_re), 16'(is_store));
		if (mis) begin
			compare_value("new_pc", redirect.new_pc, prog_val[t]);
		end
		if (writes_reg(prog_op[t])) begin
			ref_val[prog_dest[t]] = prog_val[t];
			if (ref_tag[prog_dest[t]] == lc3b_rob_addr'(t)) begin
				ref_busy[prog_dest[t]] = 1'b0; // Only the youngest producer clears
			end
			if (prog_op[t] != op_jsr) begin
				ref_nzp = cc_of(prog_val[t]);
			end
		end
		@(posedge clk);
		#2;
		head_ptr++;
		if (mis) begin
			ref_busy = '0;
			head_ptr = 0;
			tail_ptr = 0;
			compare_value("rob_empty", 16'(rob_empty), 16'd1);
		end
		check_regs();
	endtask

	task automatic finish_batch(input int first, input int n, input logic shuffle);
		fork
			complete_batch(first, n, shuffle);
			repeat (n) retire_next();
		join
	endtask

	// ####################
	// Memory responder
	// ####################

	initial begin : dmem_responder
		int waits;
		dmem_resp = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			if (dmem_write && !dmem_resp) begin
				waits = 1 + $unsigned($random(seed)) % 4;
				repeat (waits) begin
					@(posedge clk);
					#2;
					compare_value("dmem_write", 16'(dmem_write), 16'd1);
				end
				dmem_resp = 1'b1;
				@(posedge clk);
				#2;
				dmem_resp = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(num_ops * 40 * clk_period);
		$display("Watchdog timeout, the run did not end within %0d cycles", num_ops * 40);
		$display("Verification failed");
		$finish;
	end

	// ####################
	// Stimulus
	// ####################

	initial begin : stimulus
		int base;
		arst_n = 1'b0;
		alloc_valid = 1'b0;
		alloc = '0;
		complete_valid = 1'b0;
		complete = '0;
		rd_sel = '0;
		ref_busy = '0;
		ref_nzp = 3'b010;
		for (int r = 0; r < 8; r++) begin
			ref_val[r] = '0;
			ref_tag[r] = '0;
		end
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
		compare_value("rob_empty", 16'(rob_empty), 16'd1);
		compare_value("flush", 16'(flush), 16'd0);
		compare_value("pcmux_sel", 16'(redirect.pcmux_sel), 16'd0);
		compare_value("dmem_write", 16'(dmem_write), 16'd0);
		compare_value("ldstr_re", 16'(ldstr_re), 16'd0);
		check_regs();

		// Reverse completion with R1 renamed twice
		base = tail_ptr;
		alloc_op(op_add, 3'd1, 1'b0, 16'h0011);
		alloc_op(op_and, 3'd2, 1'b0, 16'h0022);
		alloc_op(op_add, 3'd1, 1'b0, 16'h0033);
		finish_batch(base, 3, 1'b0);

		// Branches around a jsr that leaves cc at n and a final mispredict
		base = tail_ptr;
		alloc_op(op_add, 3'd3, 1'b0, 16'h8000);
		alloc_op(op_br, 3'b100, 1'b1, 16'h1000);
		alloc_op(op_jsr, 3'd7, 1'b0, 16'h0000);
		alloc_op(op_br, 3'b100, 1'b1, 16'h1100);
		alloc_op(op_br, 3'b010, 1'b1, 16'h3000);
		finish_batch(base, 5, 1'b1);

		// Store between two writers
		base = tail_ptr;
		alloc_op(op_ldr, 3'd4, 1'b0, 16'h0005);
		alloc_op(op_str, 3'd0, 1'b0, 16'h0000);
		alloc_op(op_add, 3'd5, 1'b0, 16'h0007);
		finish_batch(base, 3, 1'b1);

		// Fill the buffer and hold one more allocation
		base = tail_ptr;
		for (int i = 0; i < depth; i++) begin
			alloc_op(op_add, lc3b_reg'(i % 4), 1'b0, 16'h0100 + 16'(i));
		end
		fork
			alloc_op(op_not, 3'd5, 1'b0, 16'hFFF0);
			complete_op(base % depth);
			retire_next();
		join
		finish_batch(base + 1, depth, 1'b1);

		repeat (4) begin
			base = tail_ptr;
			repeat (6) begin
				alloc_op(alu_ops[$unsigned($random(seed)) % 8], lc3b_reg'($random(seed)),
					1'b0, lc3b_word'($random(seed)));
			end
			finish_batch(base, 6, 1'b1);
		end

		repeat (2) @(posedge clk);
		#2;
		compare_value("rob_empty", 16'(rob_empty), 16'd1);
		$display("Closing: %0d check errors, %0d assertion failures", errors,
			u_commit_top.u_commit_assertions.fail_count);
		if (errors == 0 && u_commit_top.u_commit_assertions.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
